// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = axil_ram_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/axil_ram_pkg.sv ====
// Widths and codes fixed for a 32-bit data bus and a 16-bit byte address; no protection bits
`default_nettype none

package axil_ram_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int data_w     = 32;          // AXI data and RAM word width
  localparam int strb_w     = data_w / 8;  // One strobe bit per byte
  localparam int axi_addr_w = 16;          // AXI byte address width

  // --------------------
  // Response codes
  // --------------------
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;  // Range or strobe error

  // Byte address to word index
  // Assumes 4-byte words, so the two low address bits are dropped
  function automatic logic [axi_addr_w-3:0] word_index(
    input logic [axi_addr_w-1:0] addr
  );
    return addr[axi_addr_w-1:2];
  endfunction

endpackage

`default_nettype wire

// ==== design/axil_ram_top.sv ====
// AXI4-Lite scratchpad on clka only; no overlapping transactions, same-word read and write undefined
`timescale 1ns/1ps
`default_nettype none

module axil_ram_top #(
  parameter int unsigned depth   = 1024,  // Words, power of two up to 16384
  parameter int unsigned out_reg = 1      // 1 gives 2-cycle read latency
) (
  input  logic                                clka,
  input  logic                                rsta,
  // Write address
  input  logic [axil_ram_pkg::axi_addr_w-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  // Write data
  input  logic [axil_ram_pkg::data_w-1:0]     wdata,
  input  logic [axil_ram_pkg::strb_w-1:0]     wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  // Write response
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  // Read address
  input  logic [axil_ram_pkg::axi_addr_w-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  // Read data
  output logic [axil_ram_pkg::data_w-1:0]     rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready
);
  import axil_ram_pkg::*;

  localparam int addr_w = $clog2(depth);

  // --------------------
  // RAM port wiring
  // --------------------
  logic              ram_a_en;
  logic              ram_a_we;
  logic [addr_w-1:0] ram_a_addr;
  logic [data_w-1:0] ram_a_din;
  logic              ram_b_en;
  logic [addr_w-1:0] ram_b_addr;
  logic              ram_b_oreg_en;
  logic [data_w-1:0] ram_b_dout;

  // Writes enter on port A
  axil_wr_port #(
    .depth(depth)
  ) axil_wr_port_inst (
    .clka      (clka),
    .rsta      (rsta),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .ram_a_en  (ram_a_en),
    .ram_a_we  (ram_a_we),
    .ram_a_addr(ram_a_addr),
    .ram_a_din (ram_a_din)
  );

  // Port B write side tied off, port A read data unused
  tdp_ram #(
    .depth  (depth),
    .out_reg(out_reg)
  ) tdp_ram_inst (
    .clka    (clka),
    .rsta    (rsta),
    .ena     (ram_a_en),
    .wea     (ram_a_we),
    .enb     (ram_b_en),
    .web     (1'b0),
    .oreg_enb(ram_b_oreg_en),
    .addra   (ram_a_addr),
    .addrb   (ram_b_addr),
    .dina    (ram_a_din),
    .dinb    ({data_w{1'b0}}),
    .douta   (),
    .doutb   (ram_b_dout)
  );

  // Reads leave on port B
  axil_rd_port #(
    .depth  (depth),
    .out_reg(out_reg)
  ) axil_rd_port_inst (
    .clka         (clka),
    .rsta         (rsta),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .ram_b_en     (ram_b_en),
    .ram_b_addr   (ram_b_addr),
    .ram_b_oreg_en(ram_b_oreg_en),
    .ram_b_dout   (ram_b_dout)
  );

endmodule

`default_nettype wire

// ==== design/axil_rd_port.sv ====
// One read in flight; rvalid comes out_reg+1 cycles after AR, out-of-range reads return zero
`timescale 1ns/1ps
`default_nettype none

module axil_rd_port #(
  parameter int unsigned depth   = 1024,  // RAM words
  parameter int unsigned out_reg = 1      // Matches the RAM output stage
) (
  input  logic                                clka,
  input  logic                                rsta,
  // AR channel
  input  logic [axil_ram_pkg::axi_addr_w-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  // R channel
  output logic [axil_ram_pkg::data_w-1:0]     rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  // RAM port B, read only
  output logic                                ram_b_en,
  output logic [$clog2(depth)-1:0]            ram_b_addr,
  output logic                                ram_b_oreg_en,
  input  logic [axil_ram_pkg::data_w-1:0]     ram_b_dout
);
  import axil_ram_pkg::*;

  localparam int addr_w = $clog2(depth);
  localparam int cnt_w  = $clog2(out_reg + 2);  // Holds out_reg

  // State encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;  // RAM latency
  localparam logic [1:0] st_resp = 2'd2;  // rvalid high

  logic [1:0]            state;
  logic [cnt_w-1:0]      lat_cnt;     // Edges left before respond
  logic [axi_addr_w-3:0] widx;
  logic                  in_range;
  logic                  ar_hs;       // AR transfer this edge
  logic                  rd_err;      // Address was out of range
  logic                  first_wait;  // Cycle right after the RAM read

  // --------------------
  // Address decode
  // --------------------
  assign widx     = word_index(araddr);
  assign in_range = 32'(widx) < depth;
  assign ar_hs    = arvalid & arready;

  // RAM read issued on the accept edge only
  assign ram_b_en   = ar_hs & in_range;
  assign ram_b_addr = widx[addr_w-1:0];

  // Output register loads once, one cycle after the read
  assign first_wait    = (state == st_wait) && (lat_cnt == cnt_w'(out_reg));
  assign ram_b_oreg_en = first_wait & ~rd_err;

  // --------------------
  // R channel
  // --------------------
  assign rvalid = (state == st_resp);
  assign rdata  = rd_err ? '0 : ram_b_dout;  // RAM output stays put while idle
  assign rresp  = rd_err ? resp_slverr : resp_okay;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clka) begin
    if (rsta) begin
      state   <= st_idle;
      lat_cnt <= '0;
      arready <= 1'b0;  // Rises one cycle after reset
    end else begin
      // High exactly while idle
      arready <= ((state == st_idle) && !ar_hs) || ((state == st_resp) && rready);
      case (state)
        st_idle: begin
          if (ar_hs) begin
            state   <= st_wait;
            lat_cnt <= cnt_w'(out_reg);
          end
        end
        st_wait: begin
          if (lat_cnt == '0)
            state <= st_resp;
          else
            lat_cnt <= lat_cnt - 1'b1;
        end
        st_resp: begin
          if (rready)
            state <= st_idle;  // Transfer done
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Error flag captured with the address
  always_ff @(posedge clka) begin
    if (ar_hs)
      rd_err <= ~in_range;
  end

endmodule

`default_nettype wire

// ==== design/axil_wr_port.sv ====
// One write in flight; AW and W must arrive together, partial strobes and bad addresses get SLVERR
`timescale 1ns/1ps
`default_nettype none

module axil_wr_port #(
  parameter int unsigned depth = 1024  // RAM words
) (
  input  logic                                clka,
  input  logic                                rsta,
  // AW channel
  input  logic [axil_ram_pkg::axi_addr_w-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  // W channel
  input  logic [axil_ram_pkg::data_w-1:0]     wdata,
  input  logic [axil_ram_pkg::strb_w-1:0]     wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  // B channel
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  // RAM port A, write only
  output logic                                ram_a_en,
  output logic                                ram_a_we,
  output logic [$clog2(depth)-1:0]            ram_a_addr,
  output logic [axil_ram_pkg::data_w-1:0]     ram_a_din
);
  import axil_ram_pkg::*;

  localparam int addr_w = $clog2(depth);

  logic [axi_addr_w-3:0] widx;       // Word index of awaddr
  logic                  in_range;
  logic                  full_strb;  // All byte lanes written
  logic                  legal;
  logic                  accept;     // AW and W taken this edge

  // --------------------
  // Decode and legality
  // --------------------
  assign widx      = word_index(awaddr);
  assign in_range  = 32'(widx) < depth;
  assign full_strb = &wstrb;          // RAM has no byte enables
  assign legal     = in_range & full_strb;

  // Both channels accepted on the same edge, never with a response pending
  assign accept  = awvalid & wvalid & ~bvalid;
  assign awready = accept;
  assign wready  = accept;

  // Illegal writes never reach the RAM
  assign ram_a_en   = accept & legal;
  assign ram_a_we   = legal;
  assign ram_a_addr = widx[addr_w-1:0];
  assign ram_a_din  = wdata;

  // --------------------
  // Response
  // --------------------
  always_ff @(posedge clka) begin
    if (rsta) begin
      bvalid <= 1'b0;
    end else if (accept) begin
      bvalid <= 1'b1;  // Next cycle after accept
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Response code held with bvalid until bready
  always_ff @(posedge clka) begin
    if (accept)
      bresp <= legal ? resp_okay : resp_slverr;
  end

endmodule

`default_nettype wire

// ==== design/tdp_ram.sv ====
// Single clock for both ports; contents zeroed at simulation start only, rsta clears output regs
`timescale 1ns/1ps
`default_nettype none

module tdp_ram #(
  parameter int unsigned depth   = 1024,  // Number of words, power of two
  parameter int unsigned out_reg = 1      // 1 adds the output register stage
) (
  input  logic                            clka,
  input  logic                            rsta,      // Output registers only
  input  logic                            ena,       // Port A enable
  input  logic                            wea,       // Port A write
  input  logic                            enb,       // Port B enable
  input  logic                            web,       // Port B write
  input  logic                            oreg_enb,  // Port B output register load
  input  logic [$clog2(depth)-1:0]        addra,
  input  logic [$clog2(depth)-1:0]        addrb,
  input  logic [axil_ram_pkg::data_w-1:0] dina,
  input  logic [axil_ram_pkg::data_w-1:0] dinb,
  output logic [axil_ram_pkg::data_w-1:0] douta,
  output logic [axil_ram_pkg::data_w-1:0] doutb
);
  import axil_ram_pkg::*;

  logic [data_w-1:0] mem [depth];  // Storage array
  logic [data_w-1:0] ram_data_a;   // Port A read latch
  logic [data_w-1:0] ram_data_b;   // Port B read latch

  // Start from all zeros, as the block RAM does after configuration
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // --------------------
  // Port A
  // --------------------
  // No-change mode: a write leaves the read latch alone
  always @(posedge clka) begin
    if (ena) begin
      if (wea)
        mem[addra] <= dina;
      else
        ram_data_a <= mem[addra];
    end
  end

  // --------------------
  // Port B
  // --------------------
  always @(posedge clka) begin
    if (enb) begin
      if (web)
        mem[addrb] <= dinb;
      else
        ram_data_b <= mem[addrb];  // Held until the next read
    end
  end

  // --------------------
  // Output stage
  // --------------------
  generate
    if (out_reg != 0) begin : g_oreg
      logic [data_w-1:0] douta_reg;
      logic [data_w-1:0] doutb_reg;
      logic              rd_a_q;  // Port A read issued last cycle

      // Two-cycle latency, registered outputs
      always_ff @(posedge clka) begin
        if (rsta) begin
          rd_a_q    <= 1'b0;
          douta_reg <= '0;
          doutb_reg <= '0;
        end else begin
          rd_a_q <= ena & ~wea;
          if (rd_a_q)
            douta_reg <= ram_data_a;
          if (oreg_enb)
            doutb_reg <= ram_data_b;  // Load only when the reader asks
        end
      end

      assign douta = douta_reg;
      assign doutb = doutb_reg;
    end else begin : g_no_oreg
      // One-cycle latency straight from the read latches
      assign douta = ram_data_a;
      assign doutb = ram_data_b;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== sim.f ====
design/axil_ram_pkg.sv
design/tdp_ram.sv
design/axil_wr_port.sv
design/axil_rd_port.sv
design/axil_ram_top.sv
tests/axil_ram_tb.sv

// ==== tests/axil_ram_tb.sv ====
// Random AXI4-Lite traffic checked against a model; assumes depth 1024 and out_reg 1 in the DUT
`timescale 1ns/1ps
`default_nettype none

module axil_ram_tb;

  localparam int depth       = 1024;
  localparam int byte_limit  = depth * 4;        // First out-of-range byte address
  localparam logic [1:0] okay   = 2'b00;
  localparam logic [1:0] slverr = 2'b10;
  localparam int n_txn       = 184;              // Transactions over all six tests
  localparam int cycle_limit = n_txn * 20 + 5;   // 20 cycles each plus reset

  logic        clka = 1'b0;
  logic        rsta;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [15:0] lfsr = 16'd12774;   // Random source state
  logic [31:0] model_mem [depth];  // Reference copy of the RAM
  logic [15:0] addr_list [24];     // Addresses written in the stall test
  int          check_cnt = 0;
  int          err_cnt   = 0;
  int          mark_checks = 0;    // Counts at the start of the current test
  int          mark_errs   = 0;
  int          cycle_cnt   = 0;

  axil_ram_top #(
    .depth  (1024),
    .out_reg(1)
  ) axil_ram_top_inst (
    .clka(clka), .rsta(rsta),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  always #4 clka = ~clka;  // 8 ns period

  // Hard stop if a handshake hangs
  always @(posedge clka) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  // Random numbers
  // --------------------
  // Galois step, taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);   // One step per bit
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // Mostly in range, one in eight beyond unless only legal ones are wanted
  task automatic pick_addr(input logic legal_only, output logic [15:0] a);
    logic [31:0] v;
    take_bits(3, v);
    if (!legal_only && v[2:0] == 3'd0) begin
      take_bits(16, v);
      a = v[15:0] | 16'h1000;
    end else begin
      take_bits(12, v);
      a = {4'h0, v[11:0]};     // Low two bits random too
    end
  endtask

  task automatic pick_partial_strb(output logic [3:0] s);
    logic [31:0] v;
    take_bits(4, v);
    s = (v[3:0] == 4'hF) ? 4'h7 : v[3:0];  // Never all ones
  endtask

  // --------------------
  // Model and checks
  // --------------------
  function automatic logic [1:0] write_resp(input logic [15:0] addr, input logic [3:0] strb);
    return (addr < byte_limit && strb == 4'hF) ? okay : slverr;
  endfunction

  task automatic update_model(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    if (write_resp(addr, strb) == okay)
      model_mem[addr[11:2]] = data;  // Dropped writes leave the word alone
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, check_cnt - mark_checks, err_cnt - mark_errs);
    mark_checks = check_cnt;
    mark_errs   = err_cnt;
  endtask

  // --------------------
  // Bus tasks
  // --------------------
  // All tasks start and end 1 ns after a rising edge
  task automatic drive_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  task automatic wait_write_accept();
    int k;
    k = 0;
    @(negedge clka);
    while (!(awready && wready) && k < 16) begin
      k++;
      @(negedge clka);
    end
    check_cnt++;
    assert (awready && wready) else begin
      err_cnt++;
      $display("Write address and data were not accepted within 16 cycles at time %0t", $time);
    end
    @(posedge clka);  // Transfer edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // Response with bready low for stall cycles; AW must stay blocked meanwhile
  task automatic finish_write(input logic [1:0] exp_resp, input int stall);
    int         k;
    logic [1:0] resp_q;
    bready = (stall == 0);
    k = 0;
    @(negedge clka);
    while (!bvalid && k < 16) begin
      k++;
      @(negedge clka);
    end
    check_cnt++;
    assert (bvalid) else begin
      err_cnt++;
      $display("Write response never arrived at time %0t", $time);
    end
    check_value("bvalid delay after accept", k, 0);
    check_value("bresp", bresp, exp_resp);
    check_value("awready with response pending", awready, 0);
    resp_q = bresp;
    repeat (stall) begin
      @(posedge clka);
      #1;
      @(negedge clka);
      check_value("bvalid under stall", bvalid, 1);
      check_value("bresp under stall", bresp, resp_q);
      check_value("awready under stall", awready, 0);
    end
    if (stall != 0) begin
      @(posedge clka);
      #1;
      bready = 1'b1;
      @(negedge clka);
      check_value("bvalid at transfer", bvalid, 1);
    end
    @(posedge clka);  // B transfer
    #1;
    bready = 1'b0;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall);
    drive_write(addr, data, strb);
    wait_write_accept();
    update_model(addr, data, strb);
    finish_write(write_resp(addr, strb), stall);
  endtask

  task automatic read_word(input logic [15:0] addr, input int stall);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic [31:0] data_q;
    logic [1:0]  resp_q;
    int          k;
    if (addr < byte_limit) begin
      exp_data = model_mem[addr[11:2]];
      exp_resp = okay;
    end else begin
      exp_data = '0;                 // Out of range reads as zero
      exp_resp = slverr;
    end
    araddr  = addr;
    arvalid = 1'b1;
    k = 0;
    @(negedge clka);
    while (!arready && k < 16) begin
      k++;
      @(negedge clka);
    end
    check_cnt++;
    assert (arready) else begin
      err_cnt++;
      $display("Read address was not accepted within 16 cycles at time %0t", $time);
    end
    @(posedge clka);  // AR transfer edge
    #1;
    arvalid = 1'b0;
    rready  = (stall == 0);
    k = 0;
    @(negedge clka);
    while (!rvalid && k < 16) begin
      k++;
      @(negedge clka);
    end
    check_cnt++;
    assert (rvalid) else begin
      err_cnt++;
      $display("Read data never arrived at time %0t", $time);
    end
    check_value("read latency in cycles", k, 2);  // Two edges with the output register
    check_value("rdata", rdata, exp_data);
    check_value("rresp", rresp, exp_resp);
    check_value("arready with read pending", arready, 0);
    data_q = rdata;
    resp_q = rresp;
    repeat (stall) begin
      @(posedge clka);
      #1;
      @(negedge clka);
      check_value("rvalid under stall", rvalid, 1);
      check_value("rdata under stall", rdata, data_q);
      check_value("rresp under stall", rresp, resp_q);
      check_value("arready under stall", arready, 0);
    end
    if (stall != 0) begin
      @(posedge clka);
      #1;
      rready = 1'b1;
      @(negedge clka);
      check_value("rdata at transfer", rdata, data_q);
    end
    @(posedge clka);  // R transfer
    #1;
    rready = 1'b0;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] v;
    logic [31:0] d;
    logic [31:0] d2;
    logic [15:0] a;
    logic [15:0] a2;
    logic [3:0]  s;
    logic [3:0]  s2;
    int          st;
    int          st2;
    int          i;
    for (i = 0; i < depth; i++)
      model_mem[i] = '0;
    rsta    = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (5) @(posedge clka);
    #1;
    rsta = 1'b0;

    // Test 1, idle outputs then zero contents
    @(negedge clka);
    check_value("bvalid after reset", bvalid, 0);
    check_value("rvalid after reset", rvalid, 0);
    check_value("awready after reset", awready, 0);
    check_value("arready right after reset", arready, 0);
    @(negedge clka);
    check_value("arready one cycle after reset", arready, 1);
    @(posedge clka);
    #1;
    for (i = 0; i < 8; i++) begin
      pick_addr(1'b1, a);
      read_word(a, 0);
    end
    end_test("test 1 reset state");

    // Test 2, legal writes read back
    for (i = 0; i < 24; i++) begin
      pick_addr(1'b1, a);
      take_bits(32, d);
      addr_list[i] = a;
      write_word(a, d, 4'hF, 0);
    end
    for (i = 0; i < 24; i++)
      read_word(addr_list[i], 0);
    for (i = 0; i < 8; i++) begin  // Write then read at once
      pick_addr(1'b1, a);
      take_bits(32, d);
      write_word(a, d, 4'hF, 0);
      read_word(a, 0);
    end
    end_test("test 2 write and read back");

    // Test 3, dropped writes; out-of-range ones checked at the aliased word
    for (i = 0; i < 16; i++) begin
      take_bits(32, d);
      if (i % 2 == 0) begin
        take_bits(16, v);
        a = v[15:0] | 16'h1000;
        s = 4'hF;
      end else begin
        pick_addr(1'b1, a);
        pick_partial_strb(s);
      end
      write_word(a, d, s, 0);
      read_word(a & 16'h0FFF, 0);
    end
    end_test("test 3 illegal writes");

    // Test 4, out-of-range reads
    for (i = 0; i < 16; i++) begin
      take_bits(16, v);
      read_word(v[15:0] | 16'h1000, 0);
    end
    end_test("test 4 illegal reads");

    // Test 5, back-pressure with the next write queued behind the response
    for (i = 0; i < 24; i += 2) begin
      pick_addr(1'b0, a);
      take_bits(32, d);
      take_bits(2, v);
      s = 4'hF;
      if (v[1:0] == 2'd0)
        pick_partial_strb(s);
      take_bits(3, v);
      st = int'(v[2:0]);
      pick_addr(1'b0, a2);
      take_bits(32, d2);
      take_bits(2, v);
      s2 = 4'hF;
      if (v[1:0] == 2'd0)
        pick_partial_strb(s2);
      take_bits(3, v);
      st2 = int'(v[2:0]);
      addr_list[i]   = a;
      addr_list[i+1] = a2;
      drive_write(a, d, s);
      wait_write_accept();
      update_model(a, d, s);
      drive_write(a2, d2, s2);
      finish_write(write_resp(a, s), st);
      wait_write_accept();
      update_model(a2, d2, s2);
      finish_write(write_resp(a2, s2), st2);
    end
    for (i = 0; i < 24; i++) begin
      take_bits(3, v);
      read_word(addr_list[i], int'(v[2:0]));
    end
    end_test("test 5 back-pressure");

    // Test 6, read latency with rready high
    for (i = 0; i < 8; i++) begin
      pick_addr(1'b1, a);
      take_bits(32, d);
      write_word(a, d, 4'hF, 0);
      read_word(a, 0);
    end
    end_test("test 6 read latency");

    $display("Total: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
